// File: source/amo_pkg.sv
// Widths, AXI-style atomic opcode encodings and the opcode union
// Request and response structs for the processor port and the memory port
`default_nettype none

package amo_pkg;

    localparam int unsigned AddrWidth = 16;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned StrbWidth = DataWidth / 8;

    // Upper two opcode bits
    localparam logic [1:0] AtopKindNone  = 2'b00;
    localparam logic [1:0] AtopKindStore = 2'b01;
    localparam logic [1:0] AtopKindLoad  = 2'b10;
    localparam logic [1:0] AtopKindCmp   = 2'b11;

    // Full codes inside the compare kind
    localparam logic [5:0] AtopSwap = 6'b110000;
    localparam logic [5:0] AtopCmp  = 6'b110001;

    // Lower three opcode bits for atomic load and store
    localparam logic [2:0] AmoAdd  = 3'b000;
    localparam logic [2:0] AmoClr  = 3'b001;
    localparam logic [2:0] AmoEor  = 3'b010;
    localparam logic [2:0] AmoSet  = 3'b011;
    localparam logic [2:0] AmoSmax = 3'b100;
    localparam logic [2:0] AmoSmin = 3'b101;
    localparam logic [2:0] AmoUmax = 3'b110;
    localparam logic [2:0] AmoUmin = 3'b111;

    typedef union packed {
        logic [5:0] raw;
        struct packed {
            logic [1:0] kind;
            logic       big_endian;
            logic [2:0] op;
        } f;
    } atop_u;

    typedef enum logic [2:0] {
        ClassRead,
        ClassWrite,
        ClassAtomicLoad,
        ClassAtomicStore,
        ClassInvalid
    } req_class_e;

    // Processor side
    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        logic [StrbWidth-1:0] strb;
        logic [2:0]           size;
        logic                 we;
        atop_u                atop;
    } amo_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 err;
    } amo_rsp_t;

    // Memory side, single beat
    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        logic [StrbWidth-1:0] strb;
        logic                 we;
    } mem_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 err;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/amo_req_check.sv
// Request classifier: plain read or write, atomic load or store, or invalid
`timescale 1ns/1ps
`default_nettype none

module amo_req_check #(
    parameter int unsigned WordWidth = 64
) (
    input  amo_pkg::amo_req_t   req_i,
    output amo_pkg::req_class_e req_class_o
);

    import amo_pkg::*;

    // Widest size encoding the processor can issue
    localparam logic [2:0] MaxSize = 3'($clog2(WordWidth / 8));

    logic unsupported;

    // Big endian and oversized accesses are rejected for every kind
    assign unsupported = req_i.atop.f.big_endian || (req_i.size > MaxSize);

    always_comb begin
        req_class_o = ClassInvalid;
        if (!unsupported) begin
            unique case (req_i.atop.f.kind)
                AtopKindNone: begin
                    if (req_i.we) begin
                        req_class_o = ClassWrite;
                    end else begin
                        req_class_o = ClassRead;
                    end
                end
                AtopKindLoad: begin
                    req_class_o = ClassAtomicLoad;
                end
                AtopKindStore: begin
                    req_class_o = ClassAtomicStore;
                end
                AtopKindCmp: begin
                    // Only swap is handled, compare-and-swap is not
                    if (req_i.atop.raw == AtopSwap) begin
                        req_class_o = ClassAtomicLoad;
                    end else begin
                        req_class_o = ClassInvalid;
                    end
                end
                default: begin
                    req_class_o = ClassInvalid;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/amo_alu.sv
// Atomic ALU: lane select, strobe masking, the atomic operation and lane placement
`timescale 1ns/1ps
`default_nettype none

module amo_alu #(
    parameter int unsigned WordWidth = 64
) (
    input  amo_pkg::atop_u                 atop_i,
    input  logic [amo_pkg::AddrWidth-1:0]  addr_i,
    input  logic [amo_pkg::StrbWidth-1:0]  strb_i,
    input  logic [amo_pkg::DataWidth-1:0]  old_data_i,
    input  logic [amo_pkg::DataWidth-1:0]  operand_i,
    output logic [amo_pkg::DataWidth-1:0]  result_o
);

    import amo_pkg::*;

    localparam int unsigned Lanes        = DataWidth / WordWidth;
    localparam int unsigned LaneIdxWidth = (Lanes > 1) ? $clog2(Lanes) : 1;
    localparam int unsigned WordLsb      = $clog2(WordWidth / 8);

    logic [StrbWidth-1:0][7:0]       byte_mask;
    logic [Lanes-1:0][WordWidth-1:0] old_lanes;
    logic [Lanes-1:0][WordWidth-1:0] opnd_lanes;
    logic [Lanes-1:0][WordWidth-1:0] res_lanes;
    logic [LaneIdxWidth-1:0]         lane;
    logic [WordWidth-1:0]            op_a;
    logic [WordWidth-1:0]            op_b;
    logic [WordWidth-1:0]            word_res;

    always_comb begin
        for (int i = 0; i < StrbWidth; i++) begin
            byte_mask[i] = {8{strb_i[i]}};
        end
    end

    // Bytes outside the strobe do not take part
    assign old_lanes  = old_data_i & byte_mask;
    assign opnd_lanes = operand_i & byte_mask;

    if (Lanes > 1) begin : g_lane_sel
        // Word lane comes from the address bits just above the word offset
        assign lane = addr_i[WordLsb +: LaneIdxWidth];
    end else begin : g_single_lane
        assign lane = '0;
    end

    assign op_a = old_lanes[lane];
    assign op_b = opnd_lanes[lane];

    always_comb begin
        if (atop_i.raw == AtopSwap) begin
            word_res = op_b;
        end else begin
            unique case (atop_i.f.op)
                AmoAdd:  word_res = op_a + op_b;
                AmoClr:  word_res = op_a & ~op_b;
                AmoEor:  word_res = op_a ^ op_b;
                AmoSet:  word_res = op_a | op_b;
                AmoSmax: word_res = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
                AmoSmin: word_res = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
                AmoUmax: word_res = (op_a > op_b) ? op_a : op_b;
                AmoUmin: word_res = (op_a < op_b) ? op_a : op_b;
                default: word_res = op_b;
            endcase
        end
    end

    // Result back into its own lane, other lanes cleared
    always_comb begin
        res_lanes       = '0;
        res_lanes[lane] = word_res;
    end

    assign result_o = res_lanes;

endmodule

`default_nettype wire

// File: source/amo_sequencer.sv
// Request sequencer FSM: accepts one request, drives the memory port and
// builds the upstream response, including the read-modify-write of atomics
`timescale 1ns/1ps
`default_nettype none

module amo_sequencer (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  amo_pkg::amo_req_t              req_i,
    input  amo_pkg::req_class_e            req_class_i,

    input  logic [amo_pkg::DataWidth-1:0]  alu_result_i,
    output amo_pkg::amo_req_t              cap_req_o,
    output logic [amo_pkg::DataWidth-1:0]  old_data_o,

    output logic                           mem_valid_o,
    input  logic                           mem_ready_i,
    output amo_pkg::mem_req_t              mem_req_o,
    input  logic                           mem_rsp_valid_i,
    input  amo_pkg::mem_rsp_t              mem_rsp_i,

    output logic                           rsp_valid_o,
    input  logic                           rsp_ready_i,
    output amo_pkg::amo_rsp_t              rsp_o
);

    import amo_pkg::*;

    typedef enum logic [2:0] {
        StIdle,
        StReadReq,
        StReadWait,
        StWriteReq,
        StWriteWait,
        StRespond
    } state_e;

    state_e               state_q, state_d;
    amo_req_t             req_q;
    req_class_e           class_q;
    logic [DataWidth-1:0] old_q;
    amo_rsp_t             rsp_q;
    logic                 accept;

    assign accept = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            StIdle: begin
                if (req_valid_i) begin
                    unique case (req_class_i)
                        ClassRead, ClassAtomicLoad, ClassAtomicStore: state_d = StReadReq;
                        ClassWrite: state_d = StWriteReq;
                        default:    state_d = StRespond;
                    endcase
                end
            end
            StReadReq: begin
                if (mem_ready_i) begin
                    state_d = StReadWait;
                end
            end
            StReadWait: begin
                // A failed read ends an atomic without a write
                if (mem_rsp_valid_i) begin
                    if ((class_q == ClassRead) || mem_rsp_i.err) begin
                        state_d = StRespond;
                    end else begin
                        state_d = StWriteReq;
                    end
                end
            end
            StWriteReq: begin
                if (mem_ready_i) begin
                    state_d = StWriteWait;
                end
            end
            StWriteWait: begin
                if (mem_rsp_valid_i) begin
                    state_d = StRespond;
                end
            end
            StRespond: begin
                if (rsp_ready_i) begin
                    state_d = StIdle;
                end
            end
            default: begin
                state_d = StIdle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
        end else begin
            state_q <= state_d;
        end
    end

    // Captured request, old word and response under construction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q   <= req_i;
            class_q <= req_class_i;
            if (req_class_i == ClassInvalid) begin
                rsp_q <= '{rdata: '1, err: 1'b1};
            end else begin
                rsp_q <= '0;
            end
        end
        if ((state_q == StReadWait) && mem_rsp_valid_i) begin
            old_q     <= mem_rsp_i.rdata;
            rsp_q.err <= mem_rsp_i.err;
            // Atomic stores return no data
            if (class_q != ClassAtomicStore) begin
                rsp_q.rdata <= mem_rsp_i.rdata;
            end
        end
        if ((state_q == StWriteWait) && mem_rsp_valid_i) begin
            rsp_q.err <= rsp_q.err | mem_rsp_i.err;
            if (class_q == ClassWrite) begin
                rsp_q.rdata <= mem_rsp_i.rdata;
            end
        end
    end

    // Memory request follows the state, so it stays stable while waiting
    always_comb begin
        mem_req_o.addr = req_q.addr;
        mem_req_o.strb = req_q.strb;
        mem_req_o.we   = (state_q == StWriteReq);
        if (class_q == ClassWrite) begin
            mem_req_o.wdata = req_q.wdata;
        end else begin
            mem_req_o.wdata = alu_result_i;
        end
    end

    assign mem_valid_o = (state_q == StReadReq) || (state_q == StWriteReq);
    assign req_ready_o = (state_q == StIdle);
    assign rsp_valid_o = (state_q == StRespond);
    assign rsp_o       = rsp_q;

    assign cap_req_o  = req_q;
    assign old_data_o = old_q;

endmodule

`default_nettype wire

// File: source/amo_adapter_top.sv
// Atomic memory operation adapter: request checker, ALU and sequencer
`timescale 1ns/1ps
`default_nettype none

module amo_adapter_top #(
    parameter int unsigned WordWidth = 64
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  amo_pkg::amo_req_t   req_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output amo_pkg::amo_rsp_t   rsp_o,

    output logic                mem_valid_o,
    input  logic                mem_ready_i,
    output amo_pkg::mem_req_t   mem_req_o,
    input  logic                mem_rsp_valid_i,
    input  amo_pkg::mem_rsp_t   mem_rsp_i
);

    import amo_pkg::*;

    req_class_e           req_class;
    amo_req_t             cap_req;
    logic [DataWidth-1:0] old_data;
    logic [DataWidth-1:0] alu_result;

    amo_req_check #(
        .WordWidth   (WordWidth)
    ) amo_req_check_i (
        .req_i       (req_i),
        .req_class_o (req_class)
    );

    amo_alu #(
        .WordWidth  (WordWidth)
    ) amo_alu_i (
        .atop_i     (cap_req.atop),
        .addr_i     (cap_req.addr),
        .strb_i     (cap_req.strb),
        .old_data_i (old_data),
        .operand_i  (cap_req.wdata),
        .result_o   (alu_result)
    );

    amo_sequencer amo_sequencer_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_i           (req_i),
        .req_class_i     (req_class),
        .alu_result_i    (alu_result),
        .cap_req_o       (cap_req),
        .old_data_o      (old_data),
        .mem_valid_o     (mem_valid_o),
        .mem_ready_i     (mem_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_o           (rsp_o)
    );

endmodule

`default_nettype wire

// File: verification/amo_tb_sva.sv
// Handshake assertions bound to the sequencer
`timescale 1ns/1ps
`default_nettype none

module amo_sequencer_sva (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              req_valid_i,
    input logic              req_ready_o,
    input logic              mem_valid_o,
    input logic              mem_ready_i,
    input amo_pkg::mem_req_t mem_req_o,
    input logic              rsp_valid_o,
    input logic              rsp_ready_i,
    input amo_pkg::amo_rsp_t rsp_o
);

    logic outstanding_q;

    // Set by an accepted request, cleared by its response transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            outstanding_q <= 1'b1;
        end else if (rsp_valid_o && rsp_ready_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // Memory request held until the memory takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_req_o)))
        else $error("mem_valid_o or mem_req_o changed before acceptance");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
        else $error("rsp_valid_o or rsp_o changed before acceptance");

    // No new request while one is outstanding
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        outstanding_q |-> !req_ready_o)
        else $error("req_ready_o high before the previous response transferred");

    // A response only for an accepted request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o |-> outstanding_q)
        else $error("rsp_valid_o high without an accepted request");

endmodule

bind amo_sequencer amo_sequencer_sva amo_sequencer_sva_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_req_o   (mem_req_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
);

`default_nettype wire

// File: verification/amo_tb.sv
// Testbench for the atomic memory operation adapter with random requests,
// a memory model with random delay, a reference model and response checks
`timescale 1ns/1ps
`default_nettype none

module amo_tb;

    import amo_pkg::*;

    localparam int unsigned WordWidth     = 32;
    localparam int unsigned NumReqs       = 400;
    localparam int unsigned TimeoutCycles = NumReqs * 30;
    localparam int unsigned MemWords      = 32;
    localparam logic [AddrWidth-1:0] ErrBase = 16'h0F00;
    localparam logic [31:0] SignBit       = 32'h8000_0000;

    logic     clk_i;
    logic     rst_ni;
    logic     req_valid_i;
    logic     req_ready_o;
    amo_req_t req_i;
    logic     rsp_valid_o;
    logic     rsp_ready_i = 1'b0;
    amo_rsp_t rsp_o;
    logic     mem_valid_o;
    logic     mem_ready_i = 1'b0;
    mem_req_t mem_req_o;
    logic     mem_rsp_valid_i = 1'b0;
    mem_rsp_t mem_rsp_i = '0;

    logic [DataWidth-1:0] mem_array [MemWords];
    logic [DataWidth-1:0] shadow [MemWords];
    amo_rsp_t             expected_q [$];
    mem_rsp_t             mem_pending;
    int unsigned          mem_delay;
    logic                 mem_busy = 1'b0;
    int unsigned          error_count = 0;
    int unsigned          check_count = 0;
    int unsigned          sent_count = 0;
    int unsigned          rsp_count = 0;
    int unsigned          cycle_count = 0;

    amo_adapter_top #(
        .WordWidth       (WordWidth)
    ) amo_adapter_top_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_i           (req_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_o           (rsp_o),
        .mem_valid_o     (mem_valid_o),
        .mem_ready_i     (mem_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Start contents that differ for every word index
    function automatic logic [DataWidth-1:0] fill_word(int unsigned idx);
        return {32'(idx) * 32'h9E37_79B9, ~(32'(idx) * 32'h85EB_CA6B)};
    endfunction

    function automatic logic [DataWidth-1:0] merge_bytes(logic [DataWidth-1:0] old_word,
                                                         logic [DataWidth-1:0] new_word,
                                                         logic [StrbWidth-1:0] strb);
        logic [DataWidth-1:0] merged;
        merged = old_word;
        for (int b = 0; b < StrbWidth; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // 32-bit atomic operation
    // Signed order by flipping the sign bit
    function automatic logic [31:0] atomic_op(atop_u atop, logic [31:0] a, logic [31:0] b);
        logic [31:0] res;
        if (atop.raw == AtopSwap) begin
            return b;
        end
        case (atop.f.op)
            AmoAdd:  res = a + b;
            AmoClr:  res = a & ~b;
            AmoEor:  res = a ^ b;
            AmoSet:  res = a | b;
            AmoSmax: res = ((a ^ SignBit) > (b ^ SignBit)) ? a : b;
            AmoSmin: res = ((a ^ SignBit) < (b ^ SignBit)) ? a : b;
            AmoUmax: res = (a > b) ? a : b;
            default: res = (a < b) ? a : b;
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input logic [DataWidth-1:0] expected,
                               input logic [DataWidth-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d requests, %0d responses, %0d checks, %0d errors",
                 sent_count, rsp_count, check_count, error_count);
    endtask

    task automatic make_request(output amo_req_t r);
        int unsigned kind_sel;
        logic [2:0]  op;
        logic [3:0]  lane_strb;
        kind_sel  = $urandom_range(7, 0);
        op        = 3'($urandom_range(7, 0));
        lane_strb = ($urandom_range(1, 0) == 0) ? 4'hF : 4'($urandom_range(15, 1));
        r         = '0;
        r.addr    = {8'h00, 5'($urandom_range(31, 0)), 1'($urandom_range(1, 0)), 2'b00};
        if ($urandom_range(9, 0) == 0) begin
            r.addr      = ErrBase;
            r.addr[7:0] = 8'($urandom_range(255, 0)) & 8'hFC;
        end
        r.size  = 3'($urandom_range(2, 0));
        r.wdata = {$urandom, $urandom};
        r.we    = 1'b1;
        r.strb  = r.addr[2] ? {lane_strb, 4'h0} : {4'h0, lane_strb};
        case (kind_sel)
            0, 1: r.strb = 8'($urandom_range(255, 0));
            2, 3: begin
                r.we   = 1'b0;
                r.strb = 8'hFF;
            end
            4, 5: begin
                if ($urandom_range(8, 0) == 0) begin
                    r.atop.raw = AtopSwap;
                end else begin
                    r.atop.raw = {AtopKindLoad, 1'b0, op};
                end
            end
            6: r.atop.raw = {AtopKindStore, 1'b0, op};
            default: begin
                // Big endian, compare-and-swap or an oversized access
                case ($urandom_range(2, 0))
                    0: r.atop.raw = {AtopKindLoad, 1'b1, op};
                    1: r.atop.raw = AtopCmp;
                    default: begin
                        r.atop.raw = {AtopKindStore, 1'b0, op};
                        r.size     = 3'd3;
                    end
                endcase
            end
        endcase
    endtask

    // Reference model that updates the shadow memory
    task automatic predict_response(input amo_req_t r, output amo_rsp_t exp_rsp);
        logic [4:0]           idx;
        logic [DataWidth-1:0] old_word;
        logic [DataWidth-1:0] masked_old;
        logic [DataWidth-1:0] masked_opnd;
        logic [DataWidth-1:0] result;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          res;
        logic                 invalid;
        idx      = r.addr[7:3];
        old_word = shadow[idx];
        invalid  = r.atop.f.big_endian || (r.size > 3'd2) ||
                   ((r.atop.f.kind == AtopKindCmp) && (r.atop.raw != AtopSwap));
        exp_rsp  = '0;
        if (invalid) begin
            exp_rsp.rdata = '1;
            exp_rsp.err   = 1'b1;
        end else if (r.addr >= ErrBase) begin
            exp_rsp.err = 1'b1;
        end else if (r.atop.f.kind == AtopKindNone) begin
            if (r.we) begin
                shadow[idx] = merge_bytes(old_word, r.wdata, r.strb);
            end else begin
                exp_rsp.rdata = old_word;
            end
        end else begin
            // Bytes outside the strobe count as zero
            masked_old  = merge_bytes('0, old_word, r.strb);
            masked_opnd = merge_bytes('0, r.wdata, r.strb);
            a           = r.addr[2] ? masked_old[63:32] : masked_old[31:0];
            b           = r.addr[2] ? masked_opnd[63:32] : masked_opnd[31:0];
            res         = atomic_op(r.atop, a, b);
            result      = r.addr[2] ? {res, 32'h0} : {32'h0, res};
            shadow[idx] = merge_bytes(old_word, result, r.strb);
            if (r.atop.f.kind != AtopKindStore) begin
                exp_rsp.rdata = old_word;
            end
        end
    endtask

    task automatic send_request(input amo_req_t r);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= r;
        do begin
            @(posedge clk_i);
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
    endtask

    // Memory model with random ready and 1 to 4 cycles of response delay
    always @(posedge clk_i) begin
        logic [4:0] idx;
        if (!rst_ni) begin
            for (int i = 0; i < MemWords; i++) begin
                mem_array[i] <= fill_word(i);
            end
            mem_ready_i     <= 1'b0;
            mem_rsp_valid_i <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            mem_rsp_valid_i <= 1'b0;
            mem_ready_i     <= ($urandom_range(2, 0) != 0);
            if (mem_busy) begin
                if (mem_delay == 0) begin
                    mem_rsp_valid_i <= 1'b1;
                    mem_rsp_i       <= mem_pending;
                    mem_busy = 1'b0;
                end else begin
                    mem_delay--;
                end
            end else if (mem_valid_o && mem_ready_i) begin
                idx         = mem_req_o.addr[7:3];
                mem_pending = '0;
                if (mem_req_o.addr >= ErrBase) begin
                    mem_pending.err = 1'b1;
                end else if (mem_req_o.we) begin
                    mem_array[idx] <= merge_bytes(mem_array[idx], mem_req_o.wdata,
                                                  mem_req_o.strb);
                end else begin
                    mem_pending.rdata = mem_array[idx];
                end
                mem_delay = $urandom_range(3, 0);
                mem_busy  = 1'b1;
            end
        end
    end

    always @(posedge clk_i) begin
        rsp_ready_i <= ($urandom_range(3, 0) != 0);
    end

    // Responses must come one per request and in order
    always @(posedge clk_i) begin
        amo_rsp_t exp_rsp;
        if (rst_ni && rsp_valid_o && rsp_ready_i) begin
            rsp_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Response arrived while no request was outstanding");
            end else begin
                exp_rsp = expected_q.pop_front();
                check_value("rsp_o.rdata", exp_rsp.rdata, rsp_o.rdata);
                check_value("rsp_o.err", 64'(exp_rsp.err), 64'(rsp_o.err));
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TimeoutCycles) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        amo_req_t r;
        amo_rsp_t e;
        void'($urandom(12446));
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        for (int i = 0; i < MemWords; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (4) @(posedge clk_i);
        // Idle handshake outputs in reset
        check_value("req_ready_o", 64'(1'b1), 64'(req_ready_o));
        check_value("mem_valid_o", '0, 64'(mem_valid_o));
        check_value("rsp_valid_o", '0, 64'(rsp_valid_o));
        rst_ni <= 1'b1;
        for (int n = 0; n < NumReqs; n++) begin
            make_request(r);
            predict_response(r, e);
            expected_q.push_back(e);
            send_request(r);
            sent_count++;
            while (rsp_count < sent_count) begin
                @(posedge clk_i);
            end
            check_value($sformatf("mem_array[%0d]", r.addr[7:3]), shadow[r.addr[7:3]],
                        mem_array[r.addr[7:3]]);
        end
        // Nothing extra may arrive after the last request
        repeat (10) @(posedge clk_i);
        if ((rsp_count != sent_count) || (expected_q.size() != 0)) begin
            error_count++;
            $display("Response count %0d does not match request count %0d",
                     rsp_count, sent_count);
        end
        print_summary();
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/amo_pkg.sv
source/amo_req_check.sv
source/amo_alu.sv
source/amo_sequencer.sv
source/amo_adapter_top.sv
verification/amo_tb_sva.sv
verification/amo_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module amo_tb -f flist.f -o amo_sim \
    > build.log 2>&1 \
    && ./obj_dir/amo_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0
